// File: logic/fixed_point_pkg.sv
package fixed_point_pkg;

    // Signed word with 23 fraction bits, range -8 to +8
    localparam int WORD_BITS = 27;
    localparam int FRAC_BITS = 23;

    // Magnitude keeps the full integer growth of two squares
    localparam int MAG_INT_BITS = 8;
    localparam int MAG_BITS = FRAC_BITS + MAG_INT_BITS;

    localparam int PRODUCT_BITS = 2 * WORD_BITS;

    typedef logic signed [WORD_BITS-1:0] fixed_word_t;

    typedef logic signed [PRODUCT_BITS-1:0] product_t;

    typedef struct packed {
        logic [MAG_INT_BITS-1:0] int_part;
        logic [FRAC_BITS-1:0]    frac;
    } mag_fields_t;

    // Written as one word by the adder, read by field in the radius compare
    typedef union packed {
        logic [MAG_BITS-1:0] raw;
        mag_fields_t         fields;
    } mag_word_t;

endpackage

// File: logic/escape_control_pkg.sv
package escape_control_pkg;

    localparam int COUNT_BITS = 8;

    typedef logic [COUNT_BITS-1:0] count_t;

    typedef enum logic [1:0] {
        state_idle,
        state_multiply,
        state_update,
        state_done
    } escape_state_t;

endpackage

// File: logic/orbit_if.sv
`timescale 1ns/1ps

interface orbit_if
    import fixed_point_pkg::*;
();

    // Current orbit point
    fixed_word_t zre;
    fixed_word_t zim;

    // Registered squares and doubled cross product of z
    product_t p_rr;
    product_t p_ii;
    product_t p_ri2;

    modport update (
        output zre, zim,
        input  p_rr, p_ii, p_ri2
    );

    modport multiplier (
        input  zre, zim,
        output p_rr, p_ii, p_ri2
    );

endinterface

// File: logic/escape_fsm.sv
`timescale 1ns/1ps

module escape_fsm
    import escape_control_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic point_valid,
    input  logic result_ready,
    input  logic escaped,
    input  logic at_limit,
    output logic point_ready,
    output logic result_valid,
    output logic load_point,
    output logic advance
);

    escape_state_t state;
    escape_state_t state_next;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        load_point = 1'b0;
        advance    = 1'b0;
        case (state)
            state_idle: begin
                if (point_valid) begin
                    load_point = 1'b1;
                    state_next = state_multiply;
                end
            end
            // Products of the current z land at the end of this cycle
            state_multiply: begin
                state_next = state_update;
            end
            state_update: begin
                if (escaped || at_limit) begin
                    state_next = state_done;
                end else begin
                    advance    = 1'b1;
                    state_next = state_multiply;
                end
            end
            state_done: begin
                // Hold the result until it is taken
                if (result_ready) begin
                    state_next = state_idle;
                end
            end
            default: begin
                state_next = state_idle;
            end
        endcase
    end

    assign point_ready  = (state == state_idle);
    assign result_valid = (state == state_done);

endmodule

// File: logic/iteration_counter.sv
`timescale 1ns/1ps

module iteration_counter
    import escape_control_pkg::*;
#(
    parameter int MAX_ITER = 64
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   clear,
    input  logic   increment,
    output count_t count,
    output logic   at_limit
);

    localparam count_t LIMIT = count_t'(MAX_ITER);

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (increment) begin
            count <= count + count_t'(1);
        end
    end

    // Limit reached, no further update allowed
    assign at_limit = (count == LIMIT);

endmodule

// File: logic/square_multiplier.sv
`timescale 1ns/1ps

module square_multiplier
    import fixed_point_pkg::*;
(
    input logic       clock,
    input logic       reset,
    orbit_if.multiplier orbit
);

    product_t rr;
    product_t ii;
    product_t ri;

    // Full width signed products of z
    always_comb begin
        rr = orbit.zre * orbit.zre;
        ii = orbit.zim * orbit.zim;
        ri = orbit.zre * orbit.zim;
    end

    // One cycle latency, recomputed every cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            orbit.p_rr  <= '0;
            orbit.p_ii  <= '0;
            orbit.p_ri2 <= '0;
        end else begin
            orbit.p_rr  <= rr;
            orbit.p_ii  <= ii;
            orbit.p_ri2 <= ri <<< 1;
        end
    end

endmodule

// File: logic/orbit_update.sv
`timescale 1ns/1ps

module orbit_update
    import fixed_point_pkg::*;
#(
    parameter int DIVERGENCE_RADIUS = 4
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        load_point,
    input  logic        advance,
    input  fixed_word_t load_cre,
    input  fixed_word_t load_cim,
    orbit_if.update     orbit,
    output logic        escaped
);

    localparam logic [MAG_INT_BITS-1:0] RADIUS = MAG_INT_BITS'(DIVERGENCE_RADIUS);

    fixed_word_t cre;
    fixed_word_t cim;
    fixed_word_t zre;
    fixed_word_t zim;

    product_t    re_diff;
    product_t    re_shift;
    product_t    im_shift;
    fixed_word_t zre_next;
    fixed_word_t zim_next;

    // One spare bit so the sum of two squares cannot wrap
    logic [PRODUCT_BITS:0] mag_sum;
    mag_word_t             mag;

    // Point c of the orbit in flight
    always_ff @(posedge clock) begin
        if (load_point) begin
            cre <= load_cre;
            cim <= load_cim;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            zre <= '0;
            zim <= '0;
        end else if (load_point) begin
            zre <= '0;
            zim <= '0;
        end else if (advance) begin
            zre <= zre_next;
            zim <= zim_next;
        end
    end

    assign orbit.zre = zre;
    assign orbit.zim = zim;

    // z*z + c with a floor shift back to the word format and a wrapping add
    always_comb begin
        re_diff  = orbit.p_rr - orbit.p_ii;
        re_shift = re_diff >>> FRAC_BITS;
        im_shift = orbit.p_ri2 >>> FRAC_BITS;
        zre_next = fixed_word_t'(re_shift) + cre;
        zim_next = fixed_word_t'(im_shift) + cim;
    end

    // |z|^2 of the current z
    always_comb begin
        mag_sum = {1'b0, orbit.p_rr} + {1'b0, orbit.p_ii};
        mag.raw = mag_sum[FRAC_BITS +: MAG_BITS];
    end

    assign escaped = (mag.fields.int_part >= RADIUS);

endmodule

// File: logic/mandelbrot_escape.sv
`timescale 1ns/1ps

module mandelbrot_escape
    import fixed_point_pkg::*;
    import escape_control_pkg::*;
#(
    parameter int MAX_ITER          = 64,
    parameter int DIVERGENCE_RADIUS = 4
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        point_valid,
    input  fixed_word_t point_cre,
    input  fixed_word_t point_cim,
    output logic        point_ready,
    output logic        result_valid,
    input  logic        result_ready,
    output count_t      result_count,
    output logic        result_escaped
);

    logic load_point;
    logic advance;
    logic escaped;
    logic at_limit;

    orbit_if orbit ();

    escape_fsm u_escape_fsm (
        .clock        (clock),
        .reset        (reset),
        .point_valid  (point_valid),
        .result_ready (result_ready),
        .escaped      (escaped),
        .at_limit     (at_limit),
        .point_ready  (point_ready),
        .result_valid (result_valid),
        .load_point   (load_point),
        .advance      (advance)
    );

    iteration_counter #(
        .MAX_ITER (MAX_ITER)
    ) u_iteration_counter (
        .clock     (clock),
        .reset     (reset),
        .clear     (load_point),
        .increment (advance),
        .count     (result_count),
        .at_limit  (at_limit)
    );

    square_multiplier u_square_multiplier (
        .clock (clock),
        .reset (reset),
        .orbit (orbit.multiplier)
    );

    orbit_update #(
        .DIVERGENCE_RADIUS (DIVERGENCE_RADIUS)
    ) u_orbit_update (
        .clock      (clock),
        .reset      (reset),
        .load_point (load_point),
        .advance    (advance),
        .load_cre   (point_cre),
        .load_cim   (point_cim),
        .orbit      (orbit.update),
        .escaped    (escaped)
    );

    // Escape flag stays valid in done since z is frozen there
    assign result_escaped = escaped;

endmodule

// File: test/mandelbrot_escape_tb.sv
`timescale 1ns/1ps

module mandelbrot_escape_tb
    import fixed_point_pkg::*;
    import escape_control_pkg::*;
();

    localparam int MAX_ITER          = 32;
    localparam int DIVERGENCE_RADIUS = 4;

    // Run length bound
    localparam int NUM_POINTS     = 24;
    localparam int STALL_CYCLES   = 8;
    localparam int MARGIN         = 128;
    localparam int TIMEOUT_CYCLES = NUM_POINTS * 2 * (MAX_ITER + 1) + STALL_CYCLES + MARGIN;

    logic        clock;
    logic        reset;
    logic        point_valid;
    fixed_word_t point_cre;
    fixed_word_t point_cim;
    logic        point_ready;
    logic        result_valid;
    logic        result_ready;
    count_t      result_count;
    logic        result_escaped;

    logic [31:0] rng_state;
    int          cycle_count;

    mandelbrot_escape #(
        .MAX_ITER          (MAX_ITER),
        .DIVERGENCE_RADIUS (DIVERGENCE_RADIUS)
    ) u_mandelbrot_escape (
        .clock          (clock),
        .reset          (reset),
        .point_valid    (point_valid),
        .point_cre      (point_cre),
        .point_cim      (point_cim),
        .point_ready    (point_ready),
        .result_valid   (result_valid),
        .result_ready   (result_ready),
        .result_count   (result_count),
        .result_escaped (result_escaped)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $fatal(1, "run stopped on timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Maps a random word onto a coordinate strictly inside (-2, 2)
    function automatic fixed_word_t coord_from_random(input logic [31:0] r);
        longint v;
        v = longint'(r % 32'd33554431) - 64'sd16777215;
        return fixed_word_t'(v);
    endfunction

    function automatic fixed_word_t from_real(input real v);
        return fixed_word_t'($rtoi(v * (2.0 ** FRAC_BITS)));
    endfunction

    function automatic longint wrap_product(input longint v);
        logic signed [2*WORD_BITS-1:0] t;
        t = v[2*WORD_BITS-1:0];
        return longint'(t);
    endfunction

    function automatic longint wrap_word(input longint v);
        logic signed [WORD_BITS-1:0] t;
        t = v[WORD_BITS-1:0];
        return longint'(t);
    endfunction

    // Escape-time model of z = z*z + c
    function automatic void predict_escape(input fixed_word_t cre, input fixed_word_t cim,
                                           output int count, output bit escaped);
        longint zre;
        longint zim;
        longint p_rr;
        longint p_ii;
        longint p_ri2;
        longint mag_int;
        int     n;
        bit     finished;
        zre      = 0;
        zim      = 0;
        n        = 0;
        finished = 1'b0;
        count    = 0;
        escaped  = 1'b0;
        while (!finished) begin
            p_rr    = zre * zre;
            p_ii    = zim * zim;
            p_ri2   = wrap_product(2 * zre * zim);
            mag_int = ((p_rr + p_ii) >>> (2 * FRAC_BITS)) & 255;
            if (mag_int >= DIVERGENCE_RADIUS) begin
                escaped  = 1'b1;
                count    = n;
                finished = 1'b1;
            end else if (n == MAX_ITER) begin
                escaped  = 1'b0;
                count    = n;
                finished = 1'b1;
            end else begin
                zre = wrap_word(((p_rr - p_ii) >>> FRAC_BITS) + longint'(cre));
                zim = wrap_word((p_ri2 >>> FRAC_BITS) + longint'(cim));
                n   = n + 1;
            end
        end
    endfunction

    task automatic check_equal(input string test_name, input string what,
                               input longint expected, input longint actual);
        assert (expected == actual) else begin
            $display("Fail %s: %s expected %0d actual %0d", test_name, what, expected, actual);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Sends one point and checks its result and latency while the output stalls for hold_cycles
    task automatic run_point(input string test_name, input fixed_word_t cre,
                             input fixed_word_t cim, input int hold_cycles,
                             output count_t got_count, output logic got_escaped);
        int     cycles;
        int     exp_count;
        bit     exp_escaped;
        count_t held_count;
        logic   held_escaped;
        predict_escape(cre, cim, exp_count, exp_escaped);
        @(negedge clock);
        while (!point_ready) begin
            @(negedge clock);
        end
        point_valid = 1'b1;
        point_cre   = cre;
        point_cim   = cim;
        // Accept edge falls between these two negedges
        @(negedge clock);
        point_valid = 1'b0;
        cycles      = 0;
        while (!result_valid) begin
            @(negedge clock);
            cycles = cycles + 1;
        end
        got_count   = result_count;
        got_escaped = result_escaped;
        check_equal(test_name, "result_count", exp_count, result_count);
        check_equal(test_name, "result_escaped", exp_escaped, result_escaped);
        check_equal(test_name, "latency cycles", 2 * (exp_count + 1), cycles);
        held_count   = result_count;
        held_escaped = result_escaped;
        repeat (hold_cycles) begin
            @(negedge clock);
            check_equal(test_name, "result_valid under stall", 1, result_valid);
            check_equal(test_name, "point_ready under stall", 0, point_ready);
            check_equal(test_name, "held result_count", held_count, result_count);
            check_equal(test_name, "held result_escaped", held_escaped, result_escaped);
        end
        result_ready = 1'b1;
        @(negedge clock);
        result_ready = 1'b0;
        check_equal(test_name, "result_valid after take", 0, result_valid);
        check_equal(test_name, "point_ready after take", 1, point_ready);
    endtask

    task automatic verify_reset_state();
        @(negedge clock);
        check_equal("reset_state", "point_ready", 1, point_ready);
        check_equal("reset_state", "result_valid", 0, result_valid);
        check_equal("reset_state", "result_count", 0, result_count);
    endtask

    task automatic known_points();
        count_t got_count;
        logic   got_escaped;
        run_point("origin", from_real(0.0), from_real(0.0), 0, got_count, got_escaped);
        check_equal("origin", "result_count", MAX_ITER, got_count);
        check_equal("origin", "result_escaped", 0, got_escaped);
        run_point("real_1p5", from_real(1.5), from_real(0.0), 0, got_count, got_escaped);
        // Orbit 0, 1.5, 3.75 leaves the radius
        check_equal("real_1p5", "result_escaped", 1, got_escaped);
    endtask

    task automatic random_points();
        fixed_word_t cre;
        fixed_word_t cim;
        count_t      got_count;
        logic        got_escaped;
        repeat (20) begin
            rng_state = xorshift32(rng_state);
            cre       = coord_from_random(rng_state);
            rng_state = xorshift32(rng_state);
            cim       = coord_from_random(rng_state);
            run_point("random", cre, cim, 0, got_count, got_escaped);
        end
    endtask

    task automatic stall_output();
        count_t got_count;
        logic   got_escaped;
        run_point("stall_escape", from_real(1.5), from_real(0.25), STALL_CYCLES,
                  got_count, got_escaped);
        // Period two orbit that stays bounded
        run_point("after_stall", from_real(-1.0), from_real(0.0), 0, got_count, got_escaped);
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        point_valid  = 1'b0;
        point_cre    = '0;
        point_cim    = '0;
        result_ready = 1'b0;
        rng_state    = 32'h7870_fe54;
        cycle_count  = 0;

        repeat (5) @(negedge clock);
        reset = 1'b0;

        verify_reset_state();
        known_points();
        random_points();
        stall_output();

        $display("sim passed");
        $finish;
    end

endmodule

// File: mandelbrot_escape.f
logic/fixed_point_pkg.sv
logic/escape_control_pkg.sv
logic/orbit_if.sv
logic/escape_fsm.sv
logic/iteration_counter.sv
logic/square_multiplier.sv
logic/orbit_update.sv
logic/mandelbrot_escape.sv
test/mandelbrot_escape_tb.sv
